// ==== hdl/fp_adder.sv ====
`timescale 1ns/1ps

module fp_adder (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  logic [31:0] fp_a,
  input  logic [31:0] fp_b,
  input  logic [2:0]  r_mode,
  output logic        out_valid,
  output logic [31:0] fp_result,
  output logic        overflow,
  output logic        underflow
);
  import fp_pkg::*;

  // stage 1, aligned operands
  logic             s1_valid;
  logic             s1_sign_a;
  logic             s1_sign_b;
  logic [ext_w-1:0] s1_man_a;
  logic [ext_w-1:0] s1_man_b;
  logic [exp_w-1:0] s1_exp;
  logic [2:0]       s1_rmode;
  logic             s1_special;
  logic [31:0]      s1_special_word;
  logic             s1_both_neg_zero;

  // stage 2, normalized sum
  logic             s2_valid;
  logic             s2_sign;
  logic [exp_w-1:0] s2_exp;
  logic [ext_w-1:0] s2_man;
  logic             s2_zero;
  logic [2:0]       s2_rmode;
  logic             s2_special;
  logic [31:0]      s2_special_word;
  logic             s2_both_neg_zero;

  fp_align i_align (
    .clk              (clk),
    .rst              (rst),
    .in_valid         (in_valid),
    .fp_a             (fp_a),
    .fp_b             (fp_b),
    .r_mode           (r_mode),
    .s1_valid         (s1_valid),
    .s1_sign_a        (s1_sign_a),
    .s1_sign_b        (s1_sign_b),
    .s1_man_a         (s1_man_a),
    .s1_man_b         (s1_man_b),
    .s1_exp           (s1_exp),
    .s1_rmode         (s1_rmode),
    .s1_special       (s1_special),
    .s1_special_word  (s1_special_word),
    .s1_both_neg_zero (s1_both_neg_zero)
  );

  fp_normalize i_normalize (
    .clk              (clk),
    .rst              (rst),
    .s1_valid         (s1_valid),
    .s1_sign_a        (s1_sign_a),
    .s1_sign_b        (s1_sign_b),
    .s1_man_a         (s1_man_a),
    .s1_man_b         (s1_man_b),
    .s1_exp           (s1_exp),
    .s1_rmode         (s1_rmode),
    .s1_special       (s1_special),
    .s1_special_word  (s1_special_word),
    .s1_both_neg_zero (s1_both_neg_zero),
    .s2_valid         (s2_valid),
    .s2_sign          (s2_sign),
    .s2_exp           (s2_exp),
    .s2_man           (s2_man),
    .s2_zero          (s2_zero),
    .s2_rmode         (s2_rmode),
    .s2_special       (s2_special),
    .s2_special_word  (s2_special_word),
    .s2_both_neg_zero (s2_both_neg_zero)
  );

  fp_round_pack i_round_pack (
    .clk              (clk),
    .rst              (rst),
    .s2_valid         (s2_valid),
    .s2_sign          (s2_sign),
    .s2_exp           (s2_exp),
    .s2_man           (s2_man),
    .s2_zero          (s2_zero),
    .s2_rmode         (s2_rmode),
    .s2_special       (s2_special),
    .s2_special_word  (s2_special_word),
    .s2_both_neg_zero (s2_both_neg_zero),
    .out_valid        (out_valid),
    .fp_result        (fp_result),
    .overflow         (overflow),
    .underflow        (underflow)
  );

endmodule

// ==== hdl/fp_align.sv ====
`timescale 1ns/1ps

module fp_align (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logic [31:0]              fp_a,
  input  logic [31:0]              fp_b,
  input  logic [2:0]               r_mode,
  output logic                     s1_valid,
  output logic                     s1_sign_a,
  output logic                     s1_sign_b,
  output logic [fp_pkg::ext_w-1:0] s1_man_a,
  output logic [fp_pkg::ext_w-1:0] s1_man_b,
  output logic [fp_pkg::exp_w-1:0] s1_exp,
  output logic [2:0]               s1_rmode,
  output logic                     s1_special,
  output logic [31:0]              s1_special_word,
  output logic                     s1_both_neg_zero
);
  import fp_pkg::*;

  logic             sign_a;
  logic             sign_b;
  logic [exp_w-1:0] exp_a;
  logic [exp_w-1:0] exp_b;
  logic [sig_w-1:0] man_a;
  logic [sig_w-1:0] man_b;
  logic             zero_a;
  logic             zero_b;
  logic             inf_a;
  logic             inf_b;
  logic             nan_a;
  logic             nan_b;
  logic             a_larger;
  logic [exp_w-1:0] exp_diff;
  logic [ext_w-1:0] ext_a;
  logic [ext_w-1:0] ext_b;
  logic [ext_w-1:0] small_ext;
  logic [ext_w-1:0] small_shift;
  logic [ext_w-1:0] lost_mask;
  logic             any_nan;
  logic             any_inf;
  logic             inf_sign;
  logic [31:0]      special_word;

  fp_unpack i_unpack_a (
    .fp_in        (fp_a),
    .sign         (sign_a),
    .exponent     (exp_a),
    .mantissa     (man_a),
    .is_zero      (zero_a),
    .is_subnormal (),
    .is_inf       (inf_a),
    .is_nan       (nan_a)
  );

  fp_unpack i_unpack_b (
    .fp_in        (fp_b),
    .sign         (sign_b),
    .exponent     (exp_b),
    .mantissa     (man_b),
    .is_zero      (zero_b),
    .is_subnormal (),
    .is_inf       (inf_b),
    .is_nan       (nan_b)
  );

  assign ext_a = {man_a, 3'b000};
  assign ext_b = {man_b, 3'b000};

  // the operand with the smaller exponent gets shifted
  assign a_larger  = (exp_a >= exp_b);
  assign exp_diff  = a_larger ? (exp_a - exp_b) : (exp_b - exp_a);
  assign small_ext = a_larger ? ext_b : ext_a;
  assign lost_mask = ~({ext_w{1'b1}} << exp_diff);

  always_comb begin
    if (exp_diff > exp_w'(ext_w - 1)) begin
      // everything lands in sticky
      small_shift = {{(ext_w-1){1'b0}}, |small_ext};
    end else begin
      small_shift    = small_ext >> exp_diff;
      small_shift[0] = small_shift[0] | (|(small_ext & lost_mask));
    end
  end

  // NaN wins over inf, inf - inf is invalid
  assign any_nan      = nan_a | nan_b | (inf_a & inf_b & (sign_a != sign_b));
  assign any_inf      = inf_a | inf_b;
  assign inf_sign     = inf_a ? sign_a : sign_b;
  assign special_word = any_nan ? qnan_word : {inf_sign, exp_w'(exp_max), {man_w{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_sign_a        <= sign_a;
    s1_sign_b        <= sign_b;
    s1_man_a         <= a_larger ? ext_a : small_shift;
    s1_man_b         <= a_larger ? small_shift : ext_b;
    s1_exp           <= a_larger ? exp_a : exp_b;
    s1_rmode         <= r_mode;
    s1_special       <= any_nan | any_inf;
    s1_special_word  <= special_word;
    s1_both_neg_zero <= zero_a & zero_b & sign_a & sign_b;
  end

endmodule

// ==== hdl/fp_mant_addsub.sv ====
`timescale 1ns/1ps

module fp_mant_addsub (
  input  logic                     sign_a,
  input  logic                     sign_b,
  input  logic [fp_pkg::ext_w-1:0] man_a,
  input  logic [fp_pkg::ext_w-1:0] man_b,
  output logic [fp_pkg::ext_w:0]   sum,
  output logic                     sign
);
  import fp_pkg::*;

  logic same_sign;
  logic a_bigger;
  logic equal_mag;

  assign same_sign = (sign_a == sign_b);
  assign a_bigger  = (man_a > man_b);
  assign equal_mag = (man_a == man_b);

  always_comb begin
    if (same_sign) begin
      // magnitudes add, one extra bit for the carry
      sum  = {1'b0, man_a} + {1'b0, man_b};
      sign = sign_a;
    end else if (equal_mag) begin
      // exact cancellation, zero sign is fixed later by the mode
      sum  = '0;
      sign = 1'b0;
    end else if (a_bigger) begin
      sum  = {1'b0, man_a - man_b};
      sign = sign_a;
    end else begin
      sum  = {1'b0, man_b - man_a};
      sign = sign_b;
    end
  end

endmodule

// ==== hdl/fp_normalize.sv ====
`timescale 1ns/1ps

module fp_normalize (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     s1_valid,
  input  logic                     s1_sign_a,
  input  logic                     s1_sign_b,
  input  logic [fp_pkg::ext_w-1:0] s1_man_a,
  input  logic [fp_pkg::ext_w-1:0] s1_man_b,
  input  logic [fp_pkg::exp_w-1:0] s1_exp,
  input  logic [2:0]               s1_rmode,
  input  logic                     s1_special,
  input  logic [31:0]              s1_special_word,
  input  logic                     s1_both_neg_zero,
  output logic                     s2_valid,
  output logic                     s2_sign,
  output logic [fp_pkg::exp_w-1:0] s2_exp,
  output logic [fp_pkg::ext_w-1:0] s2_man,
  output logic                     s2_zero,
  output logic [2:0]               s2_rmode,
  output logic                     s2_special,
  output logic [31:0]              s2_special_word,
  output logic                     s2_both_neg_zero
);
  import fp_pkg::*;

  logic [ext_w:0]   sum;
  logic             sum_sign;
  logic [exp_w-1:0] lz;
  logic [exp_w-1:0] shift_limit;
  logic [ext_w-1:0] norm_man;
  logic [exp_w-1:0] norm_exp;

  function automatic logic [exp_w-1:0] count_lz(input logic [ext_w-1:0] value);
    logic [exp_w-1:0] count;
    logic             found;
    count = exp_w'(ext_w);
    found = 1'b0;
    for (int i = ext_w - 1; i >= 0; i--) begin
      if (value[i] && !found) begin
        count = exp_w'(ext_w - 1 - i);
        found = 1'b1;
      end
    end
    return count;
  endfunction

  fp_mant_addsub i_addsub (
    .sign_a (s1_sign_a),
    .sign_b (s1_sign_b),
    .man_a  (s1_man_a),
    .man_b  (s1_man_b),
    .sum    (sum),
    .sign   (sum_sign)
  );

  assign lz = count_lz(sum[ext_w-1:0]);

  // never shift below the minimum normal exponent
  assign shift_limit = s1_exp - 1'b1;

  always_comb begin
    if (sum[ext_w]) begin
      // carry out, fold the dropped bit into sticky
      norm_man = {sum[ext_w:2], sum[1] | sum[0]};
      norm_exp = s1_exp + 1'b1;
    end else if (lz > shift_limit) begin
      // result stays subnormal
      norm_man = sum[ext_w-1:0] << shift_limit;
      norm_exp = '0;
    end else begin
      norm_man = sum[ext_w-1:0] << lz;
      norm_exp = s1_exp - lz;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_sign          <= sum_sign;
    s2_exp           <= norm_exp;
    s2_man           <= norm_man;
    s2_zero          <= (sum == '0);
    s2_rmode         <= s1_rmode;
    s2_special       <= s1_special;
    s2_special_word  <= s1_special_word;
    s2_both_neg_zero <= s1_both_neg_zero;
  end

endmodule

// ==== hdl/fp_pkg.sv ====
package fp_pkg;

  // binary32 field widths
  localparam int exp_w = 8;
  localparam int man_w = 23;
  localparam int sig_w = 24;

  // significand with guard, round and sticky below the lsb
  localparam int ext_w = 27;

  localparam int exp_bias = 127;
  localparam int exp_max  = 255;

  // rounding-mode codes on r_mode
  localparam logic [2:0] rm_rne = 3'b000;
  localparam logic [2:0] rm_rtz = 3'b001;
  localparam logic [2:0] rm_rdn = 3'b010;
  localparam logic [2:0] rm_rup = 3'b011;
  localparam logic [2:0] rm_rmm = 3'b100;

  // canonical quiet NaN returned for every invalid sum
  localparam logic [31:0] qnan_word = 32'h7FC0_0000;

  // cycles from in_valid to out_valid
  localparam int fp_latency = 3;

endpackage

// ==== hdl/fp_round_pack.sv ====
`timescale 1ns/1ps

module fp_round_pack (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     s2_valid,
  input  logic                     s2_sign,
  input  logic [fp_pkg::exp_w-1:0] s2_exp,
  input  logic [fp_pkg::ext_w-1:0] s2_man,
  input  logic                     s2_zero,
  input  logic [2:0]               s2_rmode,
  input  logic                     s2_special,
  input  logic [31:0]              s2_special_word,
  input  logic                     s2_both_neg_zero,
  output logic                     out_valid,
  output logic [31:0]              fp_result,
  output logic                     overflow,
  output logic                     underflow
);
  import fp_pkg::*;

  logic             lsb;
  logic             guard;
  logic             rest;
  logic             inexact;
  logic             rne_up;
  logic             round_up;
  logic [sig_w:0]   rounded;
  logic [exp_w:0]   exp_r;
  logic [man_w-1:0] frac_r;
  logic             ovf;
  logic             ovf_to_inf;
  logic             zero_sign;
  logic             flag_ovf;
  logic             flag_unf;
  logic [31:0]      result_word;

  // bit 3 is the lsb, then guard, round, sticky
  assign lsb     = s2_man[3];
  assign guard   = s2_man[2];
  assign rest    = s2_man[1] | s2_man[0];
  assign inexact = guard | rest;
  assign rne_up  = guard & (rest | lsb);

  always_comb begin
    case (s2_rmode)
      rm_rne:  round_up = rne_up;
      rm_rtz:  round_up = 1'b0;
      rm_rdn:  round_up = s2_sign & inexact;
      rm_rup:  round_up = ~s2_sign & inexact;
      rm_rmm:  round_up = guard;
      // unused codes behave as nearest-even
      default: round_up = rne_up;
    endcase
  end

  assign rounded = {1'b0, s2_man[ext_w-1:3]} + {{sig_w{1'b0}}, round_up};

  always_comb begin
    if (rounded[sig_w]) begin
      // significand wrapped to 10.0...0
      exp_r  = {1'b0, s2_exp} + 1'b1;
      frac_r = rounded[sig_w-1:1];
    end else if ((s2_exp == '0) && rounded[sig_w-1]) begin
      // subnormal rounded up into the hidden bit
      exp_r  = (exp_w+1)'(1);
      frac_r = rounded[man_w-1:0];
    end else begin
      exp_r  = {1'b0, s2_exp};
      frac_r = rounded[man_w-1:0];
    end
  end

  assign ovf = (exp_r >= (exp_w+1)'(exp_max));

  // directed modes only reach inf on their own side
  always_comb begin
    case (s2_rmode)
      rm_rtz:  ovf_to_inf = 1'b0;
      rm_rdn:  ovf_to_inf = s2_sign;
      rm_rup:  ovf_to_inf = ~s2_sign;
      default: ovf_to_inf = 1'b1;
    endcase
  end

  assign zero_sign = s2_both_neg_zero | (s2_rmode == rm_rdn);

  always_comb begin
    flag_ovf = 1'b0;
    flag_unf = 1'b0;
    if (s2_special) begin
      result_word = s2_special_word;
    end else if (s2_zero) begin
      result_word = {zero_sign, {(exp_w+man_w){1'b0}}};
    end else if (ovf) begin
      flag_ovf = 1'b1;
      if (ovf_to_inf) begin
        result_word = {s2_sign, exp_w'(exp_max), {man_w{1'b0}}};
      end else begin
        result_word = {s2_sign, exp_w'(exp_max - 1), {man_w{1'b1}}};
      end
    end else begin
      // tiny after rounding and not exact
      flag_unf    = (exp_r == '0) & inexact;
      result_word = {s2_sign, exp_r[exp_w-1:0], frac_r};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      out_valid <= s2_valid;
      overflow  <= s2_valid & flag_ovf;
      underflow <= s2_valid & flag_unf;
    end
  end

  always_ff @(posedge clk) begin
    fp_result <= result_word;
  end

endmodule

// ==== hdl/fp_unpack.sv ====
`timescale 1ns/1ps

module fp_unpack (
  input  logic [31:0]              fp_in,
  output logic                     sign,
  output logic [fp_pkg::exp_w-1:0] exponent,
  output logic [fp_pkg::sig_w-1:0] mantissa,
  output logic                     is_zero,
  output logic                     is_subnormal,
  output logic                     is_inf,
  output logic                     is_nan
);
  import fp_pkg::*;

  logic [exp_w-1:0] exp_field;
  logic [man_w-1:0] frac_field;
  logic             exp_zero;
  logic             exp_ones;
  logic             frac_zero;

  assign sign       = fp_in[31];
  assign exp_field  = fp_in[30:23];
  assign frac_field = fp_in[man_w-1:0];

  assign exp_zero  = (exp_field == '0);
  assign exp_ones  = (exp_field == exp_w'(exp_max));
  assign frac_zero = (frac_field == '0);

  // hidden bit only for a nonzero exponent field
  assign mantissa = {~exp_zero, frac_field};

  // subnormals and zeros sit at the same scale as exponent 1
  assign exponent = exp_zero ? exp_w'(1) : exp_field;

  assign is_zero      = exp_zero & frac_zero;
  assign is_subnormal = exp_zero & ~frac_zero;
  assign is_inf       = exp_ones & frac_zero;
  assign is_nan       = exp_ones & ~frac_zero;

endmodule

// ==== verif/fp_adder_assert.sv ====
`timescale 1ns/1ps

module fp_adder_assert (
  input logic        clk,
  input logic        rst,
  input logic        in_valid,
  input logic        out_valid,
  input logic [31:0] fp_result,
  input logic        overflow,
  input logic        underflow
);
  import fp_pkg::*;

  // cycles since reset was released, saturating
  int since_rst = 0;

  // number of assertion failures, read by the testbench
  int fail_count = 0;

  always @(posedge clk) begin
    if (rst) begin
      since_rst <= 0;
    end else if (since_rst < 16) begin
      since_rst <= since_rst + 1;
    end
  end

  // fixed latency, no stalls
  valid_latency: assert property (@(posedge clk) disable iff (rst)
    (since_rst >= fp_latency) |-> (out_valid == $past(in_valid, fp_latency)))
    else begin
      $error("out_valid does not follow in_valid by the pipeline latency");
      fail_count++;
    end

  flags_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(overflow && underflow))
    else begin
      $error("overflow and underflow are high together");
      fail_count++;
    end

  flags_need_valid: assert property (@(posedge clk) disable iff (rst)
    !out_valid |-> (!overflow && !underflow))
    else begin
      $error("a flag is high without out_valid");
      fail_count++;
    end

  // overflow gives infinity or the largest finite value
  overflow_word: assert property (@(posedge clk) disable iff (rst)
    overflow |-> ((fp_result[30:23] == 8'hFF) || (fp_result[30:0] == 31'h7F7F_FFFF)))
    else begin
      $error("overflow result is neither infinity nor the largest finite value");
      fail_count++;
    end

endmodule

bind fp_adder fp_adder_assert i_assert (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .fp_result (fp_result),
  .overflow  (overflow),
  .underflow (underflow)
);

// ==== verif/fp_adder_tb.sv ====
`timescale 1ns/1ps

module fp_adder_tb;
  import fp_pkg::*;

  localparam int n_random   = 2000;
  // five modes times the directed vectors of each test
  localparam int n_directed = 5 * (8 + 5 + 6 + 9 + 5);
  // two 10 ns cycles per vector, plus room for the pipeline to empty
  localparam int watchdog_ns  = (n_directed + n_random + fp_latency + 20) * 10 * 2;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic [31:0] fp_a;
  logic [31:0] fp_b;
  logic [2:0]  r_mode;
  logic        out_valid;
  logic [31:0] fp_result;
  logic        overflow;
  logic        underflow;

  int cycle = 0;
  int errors = 0;
  int checks = 0;
  int issued = 0;
  int tests = 0;

  // expected {overflow, underflow, word} and the cycle each operand pair went in
  logic [33:0] exp_q[$];
  int          cyc_q[$];

  fp_adder i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .fp_a      (fp_a),
    .fp_b      (fp_b),
    .r_mode    (r_mode),
    .out_valid (out_valid),
    .fp_result (fp_result),
    .overflow  (overflow),
    .underflow (underflow)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // exact sum in units of 2^-149, then one rounding step
  function automatic logic [33:0] ref_fp_add(input logic [31:0] a, input logic [31:0] b,
                                             input logic [2:0] mode);
    logic [2:0]   rm;
    logic         a_nan;
    logic         b_nan;
    logic         a_inf;
    logic         b_inf;
    logic [7:0]   ea;
    logic [7:0]   eb;
    logic [279:0] wa;
    logic [279:0] wb;
    logic [279:0] mag;
    logic         rs;
    int           p;
    int           shift;
    int           e;
    logic [24:0]  sig;
    logic         guard;
    logic         rest;
    logic         inexact;
    logic         up;
    logic         to_inf;
    logic         ovf;
    logic         unf;
    logic [31:0]  word;
    rm    = (mode > 3'd4) ? rm_rne : mode;
    a_nan = (a[30:23] == 8'hFF) && (a[22:0] != 0);
    b_nan = (b[30:23] == 8'hFF) && (b[22:0] != 0);
    a_inf = (a[30:23] == 8'hFF) && (a[22:0] == 0);
    b_inf = (b[30:23] == 8'hFF) && (b[22:0] == 0);
    if (a_nan || b_nan || (a_inf && b_inf && (a[31] != b[31]))) begin
      return {2'b00, 32'h7FC0_0000};
    end
    if (a_inf) begin
      return {2'b00, a};
    end
    if (b_inf) begin
      return {2'b00, b};
    end
    ea = (a[30:23] == 0) ? 8'd1 : a[30:23];
    eb = (b[30:23] == 0) ? 8'd1 : b[30:23];
    wa = 280'({a[30:23] != 0, a[22:0]}) << (ea - 1);
    wb = 280'({b[30:23] != 0, b[22:0]}) << (eb - 1);
    if (a[31] == b[31]) begin
      mag = wa + wb;
      rs  = a[31];
    end else if (wa > wb) begin
      mag = wa - wb;
      rs  = a[31];
    end else begin
      mag = wb - wa;
      rs  = b[31];
    end
    if (mag == 0) begin
      // -0 only for two negative zeros or when rounding down
      rs = (a[31] & b[31]) | (rm == rm_rdn);
      return {2'b00, rs, 31'b0};
    end
    p = 0;
    for (int i = 0; i < 280; i++) begin
      if (mag[i]) p = i;
    end
    // below 2^24 units the value fits the subnormal grid exactly
    if (p <= 23) begin
      return {2'b00, rs, mag[30:0]};
    end
    shift   = p - 23;
    e       = p - 22;
    sig     = 25'(mag >> shift);
    guard   = mag[shift-1];
    rest    = (shift >= 2) ? |(mag & ~({280{1'b1}} << (shift - 1))) : 1'b0;
    inexact = guard | rest;
    case (rm)
      rm_rtz:  up = 1'b0;
      rm_rdn:  up = rs & inexact;
      rm_rup:  up = ~rs & inexact;
      rm_rmm:  up = guard;
      default: up = guard & (rest | sig[0]);
    endcase
    sig = sig + 25'(up);
    if (sig[24]) begin
      sig = sig >> 1;
      e   = e + 1;
    end
    case (rm)
      rm_rtz:  to_inf = 1'b0;
      rm_rdn:  to_inf = rs;
      rm_rup:  to_inf = ~rs;
      default: to_inf = 1'b1;
    endcase
    ovf = (e >= 255);
    if (ovf) begin
      word = to_inf ? {rs, 8'hFF, 23'h0} : {rs, 8'hFE, 23'h7F_FFFF};
    end else begin
      word = {rs, 8'(e), sig[22:0]};
    end
    unf = (word[30:23] == 0) && inexact && !ovf;
    return {ovf, unf, word};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    logic [33:0] expected;
    int          issue_cycle;
    if (!rst && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected result %h at %0t with no operands pending", fp_result, $time);
        errors++;
      end else begin
        expected    = exp_q.pop_front();
        issue_cycle = cyc_q.pop_front();
        check_value("fp_result", expected[31:0], fp_result);
        check_value("overflow", 32'(expected[33]), 32'(overflow));
        check_value("underflow", 32'(expected[32]), 32'(underflow));
        check_value("result cycle", 32'(issue_cycle + fp_latency), 32'(cycle));
      end
    end
  end

  task automatic issue(input logic [31:0] a, input logic [31:0] b, input logic [2:0] mode);
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    fp_a     = a;
    fp_b     = b;
    r_mode   = mode;
    exp_q.push_back(ref_fp_add(a, b, mode));
    cyc_q.push_back(cycle);
    issued++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    idle_cycles(1);
    waited = 0;
    while (exp_q.size() != 0 && waited < fp_latency + 10) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d results never appeared on out_valid", exp_q.size());
      errors++;
      exp_q.delete();
      cyc_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int vec_before, input int err_before);
    tests++;
    $display("%-14s %5d vectors, %0d errors", name, issued - vec_before, errors - err_before);
  endtask

  task automatic run_normal_sums();
    int v0;
    int e0;
    v0 = issued;
    e0 = errors;
    for (int m = 0; m < 5; m++) begin
      issue(32'h3F80_0000, 32'h4000_0000, 3'(m));
      issue(32'h3F80_0000, 32'hBF00_0000, 3'(m));
      issue(32'h0000_0000, 32'h0000_0000, 3'(m));
      issue(32'h000A_0000, 32'h000A_0000, 3'(m));
      // 2^24 + 1 is a tie, even and odd lsb
      issue(32'h4B80_0000, 32'h3F80_0000, 3'(m));
      issue(32'h4B80_0001, 32'h3F80_0000, 3'(m));
      issue(32'h3DCC_CCCD, 32'h3E4C_CCCD, 3'(m));
      issue(32'hC049_0FDB, 32'h3F80_0000, 3'(m));
    end
    wait_for_drain();
    report_test("normal sums", v0, e0);
  endtask

  task automatic run_cancellation();
    int v0;
    int e0;
    v0 = issued;
    e0 = errors;
    for (int m = 0; m < 5; m++) begin
      issue(32'h3F80_0000, 32'hBF80_0000, 3'(m));
      issue(32'h4120_0000, 32'hC120_0000, 3'(m));
      issue(32'h8000_0000, 32'h8000_0000, 3'(m));
      issue(32'h0000_0000, 32'h8000_0000, 3'(m));
      issue(32'h8000_0001, 32'h0000_0001, 3'(m));
    end
    wait_for_drain();
    report_test("cancellation", v0, e0);
  endtask

  task automatic run_subnormals();
    int v0;
    int e0;
    v0 = issued;
    e0 = errors;
    for (int m = 0; m < 5; m++) begin
      issue(32'h0000_0001, 32'h0000_0001, 3'(m));
      issue(32'h007F_FFFF, 32'h0000_0001, 3'(m));
      issue(32'h0040_0000, 32'h0040_0000, 3'(m));
      issue(32'h0080_0000, 32'h8000_0001, 3'(m));
      issue(32'h00C0_0000, 32'h80A0_0000, 3'(m));
      issue(32'h0100_0000, 32'h80FF_FFFF, 3'(m));
    end
    wait_for_drain();
    report_test("subnormals", v0, e0);
  endtask

  task automatic run_specials();
    int v0;
    int e0;
    v0 = issued;
    e0 = errors;
    for (int m = 0; m < 5; m++) begin
      issue(32'h7FC0_0000, 32'h3F80_0000, 3'(m));
      issue(32'h3F80_0000, 32'h7F80_0001, 3'(m));
      issue(32'h7F80_0000, 32'hFF80_0000, 3'(m));
      issue(32'hFF80_0000, 32'h7F80_0000, 3'(m));
      issue(32'h7F80_0000, 32'h3F80_0000, 3'(m));
      issue(32'hFF80_0000, 32'hC000_0000, 3'(m));
      issue(32'h7F80_0000, 32'h7F80_0000, 3'(m));
      issue(32'h7FFF_FFFF, 32'hFF80_0000, 3'(m));
      issue(32'hFF80_0000, 32'h0000_0001, 3'(m));
    end
    wait_for_drain();
    report_test("specials", v0, e0);
  endtask

  task automatic run_overflow();
    int v0;
    int e0;
    v0 = issued;
    e0 = errors;
    for (int m = 0; m < 5; m++) begin
      issue(32'h7F7F_FFFF, 32'h7F7F_FFFF, 3'(m));
      issue(32'hFF7F_FFFF, 32'hFF7F_FFFF, 3'(m));
      // half and quarter ulp of the largest value
      issue(32'h7F7F_FFFF, 32'h7300_0000, 3'(m));
      issue(32'h7F7F_FFFF, 32'h7280_0000, 3'(m));
      issue(32'hFF7F_FFFF, 32'hF300_0000, 3'(m));
    end
    wait_for_drain();
    report_test("overflow", v0, e0);
  endtask

  task automatic run_random();
    int          v0;
    int          e0;
    int          kind;
    logic [31:0] a;
    logic [31:0] b;
    v0 = issued;
    e0 = errors;
    for (int i = 0; i < n_random; i++) begin
      kind = $urandom_range(0, 4);
      a    = $urandom;
      b    = $urandom;
      case (kind)
        // near cancellation
        1: b = {~a[31], a[30:23], b[22:0]};
        2: b[30:23] = a[30:23] + 8'($urandom_range(0, 3));
        3: begin
          a[30:23] = 8'($urandom_range(0, 2));
          b[30:23] = 8'($urandom_range(0, 2));
        end
        4: begin
          a[30:23] = 8'hFE;
          b[30:23] = 8'($urandom_range(224, 254));
          b[31]    = a[31];
        end
        default: ;
      endcase
      issue(a, b, 3'($urandom_range(0, 7)));
      if ($urandom_range(0, 7) == 0) begin
        idle_cycles($urandom_range(1, 2));
      end
    end
    wait_for_drain();
    report_test("random", v0, e0);
  endtask

  initial begin
    void'($urandom(32'h3920));
    rst      = 1'b1;
    in_valid = 1'b0;
    fp_a     = '0;
    fp_b     = '0;
    r_mode   = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    run_normal_sums();
    run_cancellation();
    run_subnormals();
    run_specials();
    run_overflow();
    run_random();
    // failures seen by the bound assertion checker
    errors += i_dut.i_assert.fail_count;
    $display("summary: %0d tests, %0d vectors, %0d checks, %0d errors",
             tests, issued, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run did not complete", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/fp_pkg.sv
hdl/fp_unpack.sv
hdl/fp_align.sv
hdl/fp_mant_addsub.sv
hdl/fp_normalize.sv
hdl/fp_round_pack.sv
hdl/fp_adder.sv
verif/fp_adder_assert.sv
verif/fp_adder_tb.sv
